/* build.f */
+incdir+common
common/glue_pkg.sv
mgmt/mgmt_bridge.sv
mgmt/hdd_route.sv
hdl/reset_seq.sv
video/fb_descriptor.sv
hdl/joy_clock_gen.sv
hdl/activity_led.sv
hdl/pc_glue_top.sv
test/pc_glue_assertions.sv
test/tb_pc_glue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_pc_glue
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST)) common/glue_defs.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_pc_glue.sv */
`timescale 1ns/1ps
//========================================
// PC glue testbench
//========================================
`include "glue_defs.svh"

module tb_pc_glue
	import glue_pkg::*;
;

	localparam int CLK_PERIOD = 8;
	// Far above the summed length of all tests
	localparam int WATCHDOG_CYCLES = 20000;

	logic               clk_sys;
	logic               RESET;
	glue_opts_t         opts;
	logic               user_button;
	logic               kbc_reset_n;
	logic               host_rd;
	logic               host_wr;
	logic [15:0]        host_addr;
	logic [31:0]        host_dout;
	logic [31:0]        host_din;
	logic               io_wait;
	logic               mgmt_rd;
	logic               mgmt_we;
	logic [15:0]        mgmt_addr;
	logic [31:0]        mgmt_dout;
	logic               mgmt_wait;
	logic               mgmt_valid;
	logic [31:0]        mgmt_data;
	logic               hdd_read;
	logic               hdd_write;
	logic [15:0]        hdd_wdata;
	logic [15:0]        hdd_rdata;
	logic [1:0][15:0]   unit_rdata;
	logic [1:0]         unit_read;
	logic [1:0]         unit_write;
	logic [15:0]        unit_wdata;
	logic [7:0]         req;
	vga_mode_t          vga_mode;
	logic [7:0]         pal_a;
	logic [17:0]        pal_d;
	logic               pal_we;
	fb_desc_t           fb_desc;
	pal_wr_t            pal_wr;
	logic               f60_lock;
	logic               sys_reset;
	logic               cpu_reset;
	logic               mem_cfg;
	logic [31:0]        clock_rate;
	logic               joy_clk;
	logic               led_disk;
	logic               led_floppy;

	logic [15:0]        lfsr_state;
	int                 checks;
	int                 errors;

	pc_glue_top #(.LED_HOLD(20)) pc_glue_top_inst (.*);

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	//========================================
	// Helpers
	//========================================
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// Lands 1 ns after the edge, where inputs change and outputs settle
	task automatic next_cycle(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic compare_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("Test %s finished with %0d errors", name, errors - errs_before);
	endtask

	task automatic wait_io_done(input string what);
		int k;
		k = 0;
		while (io_wait && k < 16) begin
			next_cycle(1);
			k++;
		end
		if (io_wait) begin
			errors++;
			$display("Handshake timeout: io_wait still high after the %s", what);
		end
	endtask

	task automatic wait_joy_edge(output int cycles);
		logic prev;
		prev = joy_clk;
		cycles = 0;
		while (joy_clk == prev && cycles < 1000) begin
			next_cycle(1);
			cycles++;
		end
		if (joy_clk == prev) begin
			errors++;
			$display("joy_clk stopped toggling for 1000 cycles");
		end
	endtask

	//========================================
	// Tests
	//========================================
	task automatic test_reset_seq();
		int  errs;
		int  k;
		logic held;
		errs = errors;
		held = 1'b1;
		for (int i = 0; i < 30; i++) begin
			held = held & sys_reset;
			next_cycle(1);
		end
		compare_value("sys_reset before first host reset", 32'(held), 32'd1);
		opts.reset_req = 1'b1;
		next_cycle(1);
		opts.reset_req = 1'b0;
		k = 1;
		while (sys_reset && k < 3 + `GLUE_RST_STRETCH) begin
			next_cycle(1);
			k++;
		end
		if (sys_reset) begin
			errors++;
			$display("sys_reset did not fall within 11 cycles of the reset request");
		end
		held = 1'b0;
		for (int i = 0; i < 10; i++) begin
			held = held | sys_reset;
			next_cycle(1);
		end
		compare_value("sys_reset after stretch", 32'(held), 32'd0);
		// Memory size is taken while the button holds the CPU
		opts.mem_small = 1'b1;
		user_button = 1'b1;
		next_cycle(3);
		compare_value("cpu_reset with button", 32'(cpu_reset), 32'd1);
		user_button = 1'b0;
		next_cycle(3);
		compare_value("cpu_reset after button", 32'(cpu_reset), 32'd0);
		compare_value("mem_cfg latched", 32'(mem_cfg), 32'd1);
		opts.mem_small = 1'b0;
		next_cycle(2);
		compare_value("mem_cfg outside CPU reset", 32'(mem_cfg), 32'd1);
		report_test("reset_seq", errs);
	endtask

	task automatic mgmt_read(input int hold, input logic [31:0] d);
		host_rd = 1'b1;
		mgmt_wait = 1'b1;
		next_cycle(1);
		host_rd = 1'b0;
		compare_value("mgmt_rd raised", 32'(mgmt_rd), 32'd1);
		compare_value("io_wait on read", 32'(io_wait), 32'd1);
		for (int i = 0; i < hold; i++) begin
			next_cycle(1);
			compare_value("mgmt_rd held", 32'(mgmt_rd), 32'd1);
			compare_value("io_wait held on read", 32'(io_wait), 32'd1);
		end
		mgmt_wait = 1'b0;
		mgmt_valid = 1'b1;
		mgmt_data = d;
		next_cycle(1);
		mgmt_valid = 1'b0;
		mgmt_data = '0;
		wait_io_done("read");
		compare_value("host_din", host_din, d);
		compare_value("mgmt_rd after read", 32'(mgmt_rd), 32'd0);
	endtask

	task automatic mgmt_write(input int hold, input logic [31:0] d, input logic [15:0] a);
		host_wr = 1'b1;
		host_dout = d;
		host_addr = a;
		mgmt_wait = 1'b1;
		next_cycle(1);
		host_wr = 1'b0;
		compare_value("mgmt_we raised", 32'(mgmt_we), 32'd1);
		compare_value("io_wait on write", 32'(io_wait), 32'd1);
		compare_value("mgmt_dout", mgmt_dout, d);
		compare_value("mgmt_addr", 32'(mgmt_addr), 32'(a));
		for (int i = 0; i < hold; i++) begin
			next_cycle(1);
			compare_value("mgmt_we held", 32'(mgmt_we), 32'd1);
			compare_value("io_wait held on write", 32'(io_wait), 32'd1);
		end
		mgmt_wait = 1'b0;
		next_cycle(1);
		wait_io_done("write");
		compare_value("mgmt_we after write", 32'(mgmt_we), 32'd0);
	endtask

	task automatic test_mgmt();
		int          errs;
		logic [31:0] r;
		logic [31:0] d;
		errs = errors;
		rand_bits(2, r);
		rand_bits(32, d);
		mgmt_read(int'(r[1:0]) + 1, d);
		rand_bits(2, r);
		rand_bits(32, d);
		mgmt_write(int'(r[1:0]) + 1, d, d[31:16]);
		report_test("mgmt", errs);
	endtask

	task automatic test_disk();
		int          errs;
		logic [31:0] r;
		logic        sel;
		logic        wr;
		errs = errors;
		for (int i = 0; i < 8; i++) begin
			rand_bits(1, r);
			sel = r[0];
			rand_bits(1, r);
			wr = r[0];
			rand_bits(16, r);
			hdd_wdata = r[15:0];
			rand_bits(32, r);
			unit_rdata = r;
			host_addr = {15'd0, sel};
			hdd_read = ~wr;
			hdd_write = wr;
			next_cycle(1);
			hdd_read = 1'b0;
			hdd_write = 1'b0;
			compare_value("unit_read", 32'(unit_read), wr ? 32'd0 : (32'd1 << sel));
			compare_value("unit_write", 32'(unit_write), wr ? (32'd1 << sel) : 32'd0);
			compare_value("unit_wdata", 32'(unit_wdata), 32'(hdd_wdata));
			compare_value("hdd_rdata", 32'(hdd_rdata), sel ? 32'(r[31:16]) : 32'(r[15:0]));
			next_cycle(1);
			compare_value("unit strobes idle", 32'({unit_read, unit_write}), 32'd0);
		end
		report_test("disk", errs);
	endtask

	task automatic check_fb_mode(input logic [1:0] depth, input logic text, input logic dscan);
		logic [31:0] r;
		logic [11:0] exp_w;
		logic [11:0] exp_h;
		logic [2:0]  code;
		logic        exp_en;
		rand_bits(20, r);
		vga_mode.start_addr = r[19:0];
		rand_bits(9, r);
		vga_mode.width = r[8:0];
		rand_bits(9, r);
		vga_mode.stride = r[8:0];
		rand_bits(11, r);
		vga_mode.height = r[10:0];
		rand_bits(1, r);
		vga_mode.off = r[0];
		vga_mode.flags = {dscan, text, depth};
		next_cycle(1);
		exp_en = !text && depth != 2'd0;
		code = (depth == 2'd1) ? 3'd3 : (depth == 2'd2) ? 3'd4 : 3'd5;
		if (depth == 2'd3) begin
			exp_w = 12'd640;
		end else if (text) begin
			exp_w = {3'b000, vga_mode.width} * 12'd4;
		end else begin
			exp_w = {3'b000, vga_mode.width} * 12'd8;
		end
		exp_h = dscan ? {1'b0, vga_mode.height} / 12'd2 : {1'b0, vga_mode.height};
		compare_value("fb en", 32'(fb_desc.en), 32'(exp_en));
		compare_value("fb format", 32'(fb_desc.format),
			32'(code) + (opts.fmt_565 ? 32'd0 : 32'd8) + (opts.rgb_order ? 32'd0 : 32'd16));
		compare_value("fb width", 32'(fb_desc.width), 32'(exp_w));
		compare_value("fb height", 32'(fb_desc.height), 32'(exp_h));
		compare_value("fb base", fb_desc.base,
			(32'(`GLUE_FB_BASE_PREFIX) << 22) | (32'(vga_mode.start_addr) << 2));
		compare_value("fb stride", 32'(fb_desc.stride),
			32'({5'b00000, vga_mode.stride} * 14'd8));
		compare_value("fb blank", 32'(fb_desc.force_blank), 32'(vga_mode.off));
		next_cycle(1);
		compare_value("f60_lock", 32'(f60_lock),
			32'(!opts.vsync_variable || exp_en || exp_w >= 12'd800));
	endtask

	task automatic test_fb();
		int          errs;
		logic [31:0] r;
		errs = errors;
		opts.vsync_variable = 1'b1;
		rand_bits(2, r);
		opts.rgb_order = r[0];
		opts.fmt_565 = r[1];
		check_fb_mode(2'd1, 1'b0, 1'b0);
		check_fb_mode(2'd2, 1'b0, 1'b1);
		check_fb_mode(2'd3, 1'b0, 1'b0);
		check_fb_mode(2'd1, 1'b1, 1'b1);
		rand_bits(26, r);
		pal_a = r[25:18];
		pal_d = r[17:0];
		pal_we = 1'b1;
		#1;
		compare_value("pal addr", 32'(pal_wr.addr), 32'(pal_a));
		compare_value("pal we", 32'(pal_wr.we), 32'd1);
		// Each 6-bit component gets its top two bits appended
		compare_value("pal data", 32'(pal_wr.data), 32'({pal_d[17:12], pal_d[17:16],
			pal_d[11:6], pal_d[11:10], pal_d[5:0], pal_d[5:4]}));
		next_cycle(1);
		pal_we = 1'b0;
		report_test("fb", errs);
	endtask

	task automatic test_joy_led();
		int   errs;
		int   c;
		int   k;
		logic floppy_lit;
		errs = errors;
		opts.speed = 3'd2;
		next_cycle(1);
		compare_value("clock_rate", clock_rate, 32'd15000000);
		// Let the accumulator drain from the old rate
		next_cycle(20);
		wait_joy_edge(c);
		for (int i = 0; i < 2; i++) begin
			wait_joy_edge(c);
			compare_value($sformatf("joy_clk spacing of %0d cycles", c),
				32'(c >= 374 && c <= 376), 32'd1);
		end
		req = 8'h08;
		next_cycle(1);
		req = 8'h00;
		compare_value("led_disk lit", 32'(led_disk), 32'd1);
		compare_value("led_floppy dark", 32'(led_floppy), 32'd0);
		next_cycle(5);
		req = 8'h08;
		next_cycle(1);
		req = 8'h00;
		k = 0;
		floppy_lit = 1'b0;
		while (led_disk && k < 100) begin
			floppy_lit = floppy_lit | led_floppy;
			next_cycle(1);
			k++;
		end
		compare_value($sformatf("led_disk hold of %0d cycles", k),
			32'(k >= 19 && k <= 21), 32'd1);
		compare_value("led_floppy during disk activity", 32'(floppy_lit), 32'd0);
		report_test("joy_led", errs);
	endtask

	//========================================
	// Main sequence
	//========================================
	initial begin
		lfsr_state = 16'd7394;
		checks = 0;
		errors = 0;
		RESET = 1'b1;
		opts = '0;
		user_button = 1'b0;
		kbc_reset_n = 1'b1;
		host_rd = 1'b0;
		host_wr = 1'b0;
		host_addr = '0;
		host_dout = '0;
		mgmt_wait = 1'b0;
		mgmt_valid = 1'b0;
		mgmt_data = '0;
		hdd_read = 1'b0;
		hdd_write = 1'b0;
		hdd_wdata = '0;
		unit_rdata = '0;
		req = '0;
		vga_mode = '0;
		pal_a = '0;
		pal_d = '0;
		pal_we = 1'b0;
		next_cycle(3);
		RESET = 1'b0;
		test_reset_seq();
		test_mgmt();
		test_disk();
		test_fb();
		test_joy_led();
		$display("Done: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* test/pc_glue_assertions.sv */
`timescale 1ns/1ps
//========================================
// Management bridge assertions
//========================================

module pc_glue_assertions (
	input logic clk_sys,
	input logic RESET,
	input logic host_rd,
	input logic host_wr,
	input logic mgmt_wait,
	input logic mgmt_rd,
	input logic mgmt_we,
	input logic io_wait
);

	// Host is stalled right after any strobe
	strobe_stalls: assert property (@(posedge clk_sys) disable iff (RESET)
		(host_rd || host_wr) |=> io_wait)
		else $error("io_wait not raised after a host strobe");

	// Back-pressure keeps the request up
	read_holds: assert property (@(posedge clk_sys) disable iff (RESET)
		(mgmt_rd && mgmt_wait) |=> mgmt_rd)
		else $error("mgmt_rd dropped under mgmt_wait");

	write_holds: assert property (@(posedge clk_sys) disable iff (RESET)
		(mgmt_we && mgmt_wait) |=> mgmt_we)
		else $error("mgmt_we dropped under mgmt_wait");

	no_overlap: assert property (@(posedge clk_sys) disable iff (RESET)
		!(mgmt_rd && mgmt_we))
		else $error("mgmt_rd and mgmt_we high together");

endmodule

bind mgmt_bridge pc_glue_assertions mgmt_bridge_checks (
	.clk_sys   (clk_sys),
	.RESET     (RESET),
	.host_rd   (host_rd),
	.host_wr   (host_wr),
	.mgmt_wait (mgmt_wait),
	.mgmt_rd   (mgmt_rd),
	.mgmt_we   (mgmt_we),
	.io_wait   (io_wait)
);

/* hdl/pc_glue_top.sv */
`timescale 1ns/1ps
//========================================
// PC core board glue
//========================================
`include "glue_defs.svh"

module pc_glue_top
	import glue_pkg::*;
#(
	parameter int LED_HOLD = `GLUE_LED_HOLD
) (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  glue_opts_t                   opts,
	input  logic                         user_button,
	input  logic                         kbc_reset_n,

	// Host side
	input  logic                         host_rd,
	input  logic                         host_wr,
	input  logic [`GLUE_MGMT_ADDR_W-1:0] host_addr,
	input  mgmt_word_t                   host_dout,
	output mgmt_word_t                   host_din,
	output logic                         io_wait,

	// Core management bus
	output logic                         mgmt_rd,
	output logic                         mgmt_we,
	output logic [`GLUE_MGMT_ADDR_W-1:0] mgmt_addr,
	output mgmt_word_t                   mgmt_dout,
	input  logic                         mgmt_wait,
	input  logic                         mgmt_valid,
	input  mgmt_word_t                   mgmt_data,

	// Disk data
	input  logic                         hdd_read,
	input  logic                         hdd_write,
	input  hdd_word_t                    hdd_wdata,
	output hdd_word_t                    hdd_rdata,
	input  hdd_word_t [1:0]              unit_rdata,
	output logic [1:0]                   unit_read,
	output logic [1:0]                   unit_write,
	output hdd_word_t                    unit_wdata,
	input  logic [`GLUE_REQ_W-1:0]       req,

	// Video
	input  vga_mode_t                    vga_mode,
	input  logic [7:0]                   pal_a,
	input  logic [17:0]                  pal_d,
	input  logic                         pal_we,
	output fb_desc_t                     fb_desc,
	output pal_wr_t                      pal_wr,
	output logic                         f60_lock,

	output logic                         sys_reset,
	output logic                         cpu_reset,
	output logic                         mem_cfg,
	output logic [31:0]                  clock_rate,
	output logic                         joy_clk,
	output logic                         led_disk,
	output logic                         led_floppy
);

	//========================================
	// Input side
	//========================================
	assign mgmt_addr = host_addr;
	assign mgmt_dout = host_dout;

	mgmt_bridge mgmt_bridge_inst (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.host_rd    (host_rd),
		.host_wr    (host_wr),
		.mgmt_wait  (mgmt_wait),
		.mgmt_valid (mgmt_valid),
		.mgmt_data  (mgmt_data),
		.mgmt_rd    (mgmt_rd),
		.mgmt_we    (mgmt_we),
		.host_din   (host_din),
		.io_wait    (io_wait)
	);

	// Low address bit picks the disk unit
	hdd_route hdd_route_inst (
		.clk_sys    (clk_sys),
		.sel        (mgmt_addr[0]),
		.hdd_read   (hdd_read),
		.hdd_write  (hdd_write),
		.hdd_wdata  (hdd_wdata),
		.unit_rdata (unit_rdata),
		.unit_read  (unit_read),
		.unit_write (unit_write),
		.unit_wdata (unit_wdata),
		.hdd_rdata  (hdd_rdata)
	);

	//========================================
	// Processing
	//========================================
	reset_seq reset_seq_inst (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.opts        (opts),
		.user_button (user_button),
		.kbc_reset_n (kbc_reset_n),
		.sys_reset   (sys_reset),
		.cpu_reset   (cpu_reset),
		.mem_cfg     (mem_cfg)
	);

	fb_descriptor fb_descriptor_inst (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.vga_mode (vga_mode),
		.opts     (opts),
		.pal_a    (pal_a),
		.pal_d    (pal_d),
		.pal_we   (pal_we),
		.fb_desc  (fb_desc),
		.pal_wr   (pal_wr),
		.f60_lock (f60_lock)
	);

	joy_clock_gen joy_clock_gen_inst (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.speed      (opts.speed),
		.clock_rate (clock_rate),
		.joy_clk    (joy_clk)
	);

	//========================================
	// Output side
	//========================================
	// Bits 5:0 are the two disk units, 7:6 the floppy
	activity_led #(.HOLD_CYCLES(LED_HOLD)) led_disk_inst (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.activity (|req[5:0]),
		.led      (led_disk)
	);

	activity_led #(.HOLD_CYCLES(LED_HOLD)) led_floppy_inst (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.activity (|req[7:6]),
		.led      (led_floppy)
	);

endmodule

/* hdl/activity_led.sv */
`timescale 1ns/1ps
//========================================
// LED pulse stretcher
//========================================
`include "glue_defs.svh"

module activity_led #(
	parameter int HOLD_CYCLES = `GLUE_LED_HOLD
) (
	input  logic clk_sys,
	input  logic RESET,
	input  logic activity,
	output logic led
);

	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	logic [CNT_W-1:0] cnt;

	// Any new activity restarts the hold time
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cnt <= '0;
		end else if (activity) begin
			cnt <= HOLD_CYCLES[CNT_W-1:0];
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign led = (cnt != '0);

endmodule

/* hdl/joy_clock_gen.sv */
`timescale 1ns/1ps
//========================================
// Joystick sampling clock
//========================================
`include "glue_defs.svh"

module joy_clock_gen
	import glue_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	input  speed_t      speed,
	output logic [31:0] clock_rate,
	output logic        joy_clk
);

	logic [31:0] acc;
	logic [31:0] acc_sum;

	// Unused speed codes fall back to the first rate
	always_ff @(posedge clk_sys) begin
		case (speed)
			3'd1:    clock_rate <= `GLUE_RATE_1;
			3'd2:    clock_rate <= `GLUE_RATE_2;
			3'd3:    clock_rate <= `GLUE_RATE_3;
			3'd4:    clock_rate <= `GLUE_RATE_4;
			default: clock_rate <= `GLUE_RATE_0;
		endcase
	end

	assign acc_sum = acc + `GLUE_JOY_STEP;

	// Toggles at step/rate times the clk_sys rate
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			acc     <= '0;
			joy_clk <= 1'b0;
		end else if (acc_sum >= clock_rate) begin
			acc     <= acc_sum - clock_rate;
			joy_clk <= ~joy_clk;
		end else begin
			acc <= acc_sum;
		end
	end

endmodule

/* video/fb_descriptor.sv */
`timescale 1ns/1ps
//========================================
// Framebuffer descriptor
//========================================
`include "glue_defs.svh"

module fb_descriptor
	import glue_pkg::*;
(
	input  logic       clk_sys,
	input  logic       RESET,
	input  vga_mode_t  vga_mode,
	input  glue_opts_t opts,
	input  logic [7:0] pal_a,
	input  logic [17:0] pal_d,
	input  logic       pal_we,
	output fb_desc_t   fb_desc,
	output pal_wr_t    pal_wr,
	output logic       f60_lock
);

	logic [1:0] depth;
	logic       text;
	logic       dscan;
	logic [2:0] fmt_lo;
	fb_desc_t   desc_next;

	assign depth = vga_mode.flags[1:0];
	assign text  = vga_mode.flags[2];
	assign dscan = vga_mode.flags[3];

	// Repeat the top bits to fill 8 bits
	function automatic logic [7:0] widen6(input logic [5:0] c);
		return {c, c[5:4]};
	endfunction

	always_comb begin
		case (depth)
			2'd3:    fmt_lo = `GLUE_FMT_24BPP;
			2'd2:    fmt_lo = `GLUE_FMT_16BPP;
			default: fmt_lo = `GLUE_FMT_8BPP;
		endcase

		desc_next.en     = ~text && (depth != 2'd0);
		// Bit 3 picks 1555 over 565, bit 4 picks BGR over RGB
		desc_next.format = {~opts.rgb_order, ~opts.fmt_565, fmt_lo};
		if (depth == 2'd3) begin
			desc_next.width = `GLUE_FB_WIDTH_24BPP;
		end else if (text) begin
			desc_next.width = {1'b0, vga_mode.width, 2'b00};
		end else begin
			desc_next.width = {vga_mode.width, 3'b000};
		end
		desc_next.height      = dscan ? {2'b00, vga_mode.height[10:1]} : {1'b0, vga_mode.height};
		desc_next.base        = {`GLUE_FB_BASE_PREFIX, vga_mode.start_addr, 2'b00};
		desc_next.stride      = {2'b00, vga_mode.stride, 3'b000};
		desc_next.force_blank = vga_mode.off;
	end

	always_ff @(posedge clk_sys) begin
		fb_desc <= desc_next;
		if (RESET) begin
			fb_desc.en <= 1'b0;
		end
	end

	// Lock to 60 Hz for framebuffer modes and wide screens
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			f60_lock <= 1'b0;
		end else begin
			f60_lock <= ~opts.vsync_variable | fb_desc.en |
				(fb_desc.width >= `GLUE_F60_MIN_WIDTH);
		end
	end

	// 18-bit palette entry widened to 24 bits without a register
	always_comb begin
		pal_wr.addr = pal_a;
		pal_wr.data = {widen6(pal_d[17:12]), widen6(pal_d[11:6]), widen6(pal_d[5:0])};
		pal_wr.we   = pal_we;
	end

endmodule

/* hdl/reset_seq.sv */
`timescale 1ns/1ps
//========================================
// Reset sequencer
//========================================
`include "glue_defs.svh"

module reset_seq
	import glue_pkg::*;
(
	input  logic       clk_sys,
	input  logic       RESET,
	input  glue_opts_t opts,
	input  logic       user_button,
	input  logic       kbc_reset_n,
	output logic       sys_reset,
	output logic       cpu_reset,
	output logic       mem_cfg
);

	localparam int STRETCH = `GLUE_RST_STRETCH;

	logic [STRETCH-1:0] rst_q;
	logic               req_d1;
	logic               req_d2;
	logic               init_done;
	logic               cpu_rst_q;
	logic               req_rise;

	assign req_rise = req_d1 & ~req_d2;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			req_d1    <= 1'b0;
			req_d2    <= 1'b0;
			rst_q     <= '0;
			init_done <= 1'b0;
			cpu_rst_q <= 1'b0;
		end else begin
			req_d1    <= opts.reset_req;
			req_d2    <= req_d1;
			cpu_rst_q <= user_button | opts.reset_req | ~kbc_reset_n;
			// Ones drain out of the top bit one per cycle
			if (req_rise) begin
				rst_q     <= '1;
				init_done <= 1'b1;
			end else begin
				rst_q <= {rst_q[STRETCH-2:0], 1'b0};
			end
		end
	end

	// Held in reset until the host asks for the first one
	assign sys_reset = rst_q[STRETCH-1] | ~init_done;
	assign cpu_reset = cpu_rst_q | sys_reset;

	// Memory size only changes while the CPU is held
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			mem_cfg <= opts.mem_small;
		end
	end

endmodule

/* mgmt/hdd_route.sv */
`timescale 1ns/1ps
//========================================
// Disk data routing
//========================================

module hdd_route
	import glue_pkg::*;
(
	input  logic            clk_sys,
	input  logic            sel,
	input  logic            hdd_read,
	input  logic            hdd_write,
	input  hdd_word_t       hdd_wdata,
	input  hdd_word_t [1:0] unit_rdata,
	output logic [1:0]      unit_read,
	output logic [1:0]      unit_write,
	output hdd_word_t       unit_wdata,
	output hdd_word_t       hdd_rdata
);

	// Index 0 is the primary unit, 1 the secondary
	always_ff @(posedge clk_sys) begin
		unit_read  <= {hdd_read & sel, hdd_read & ~sel};
		unit_write <= {hdd_write & sel, hdd_write & ~sel};
		// Both units see the same write word
		unit_wdata <= hdd_wdata;
		hdd_rdata  <= unit_rdata[sel];
	end

endmodule

/* mgmt/mgmt_bridge.sv */
`timescale 1ns/1ps
//========================================
// Host to management bus bridge
//========================================

module mgmt_bridge
	import glue_pkg::*;
(
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic       host_rd,
	input  logic       host_wr,
	input  logic       mgmt_wait,
	input  logic       mgmt_valid,
	input  mgmt_word_t mgmt_data,
	output logic       mgmt_rd,
	output logic       mgmt_we,
	output mgmt_word_t host_din,
	output logic       io_wait
);

	// Later assignments in this block take priority
	always_ff @(posedge clk_sys) begin
		if (!mgmt_wait) begin
			mgmt_rd <= 1'b0;
			mgmt_we <= 1'b0;
		end
		if (host_rd) begin
			mgmt_rd <= 1'b1;
		end
		if (host_wr) begin
			mgmt_we <= 1'b1;
		end

		// Read ends with valid data, write ends once accepted
		if (mgmt_valid || (!mgmt_wait && mgmt_we)) begin
			io_wait <= 1'b0;
		end
		if (host_rd || host_wr) begin
			io_wait <= 1'b1;
		end

		if (RESET) begin
			mgmt_rd <= 1'b0;
			mgmt_we <= 1'b0;
			io_wait <= 1'b0;
		end
	end

	// Read data capture
	always_ff @(posedge clk_sys) begin
		if (mgmt_valid) begin
			host_din <= mgmt_data;
		end
	end

endmodule

/* common/glue_pkg.sv */
//========================================
// Shared glue types
//========================================
`include "glue_defs.svh"

package glue_pkg;

	typedef logic [`GLUE_MGMT_DATA_W-1:0] mgmt_word_t;
	typedef logic [`GLUE_HDD_WORD_W-1:0]  hdd_word_t;
	typedef logic [2:0]                   speed_t;

	// Host option bits
	typedef struct packed {
		logic   reset_req;
		logic   vsync_variable;
		logic   rgb_order;
		logic   fmt_565;
		speed_t speed;
		logic   mem_small;
	} glue_opts_t;

	// Video mode as reported by the core
	typedef struct packed {
		logic [19:0] start_addr;
		logic [8:0]  width;
		logic [8:0]  stride;
		logic [10:0] height;
		logic [3:0]  flags;
		logic        off;
	} vga_mode_t;

	typedef struct packed {
		logic        en;
		logic [4:0]  format;
		logic [11:0] width;
		logic [11:0] height;
		logic [31:0] base;
		logic [13:0] stride;
		logic        force_blank;
	} fb_desc_t;

	typedef struct packed {
		logic [7:0]  addr;
		logic [23:0] data;
		logic        we;
	} pal_wr_t;

endpackage

/* common/glue_defs.svh */
//========================================
// Glue widths and constants
//========================================
`ifndef GLUE_DEFS_SVH
`define GLUE_DEFS_SVH

// Bus widths
`define GLUE_MGMT_DATA_W    32
`define GLUE_MGMT_ADDR_W    16
`define GLUE_HDD_WORD_W     16
`define GLUE_REQ_W          8

// Framebuffer constants
`define GLUE_FB_BASE_PREFIX 10'b0011111110
`define GLUE_FMT_8BPP       3'd3
`define GLUE_FMT_16BPP      3'd4
`define GLUE_FMT_24BPP      3'd5
`define GLUE_FB_WIDTH_24BPP 12'd640
`define GLUE_F60_MIN_WIDTH  12'd800

// Reset pulse length in clk_sys cycles
`define GLUE_RST_STRETCH    8

// Joystick step and core clock rates in Hz
`define GLUE_JOY_STEP       32'd40000
`define GLUE_RATE_0         32'd90000000
`define GLUE_RATE_1         32'd100000000
`define GLUE_RATE_2         32'd15000000
`define GLUE_RATE_3         32'd30000000
`define GLUE_RATE_4         32'd56250000

// Roughly 50 ms of LED afterglow at 90 MHz
`define GLUE_LED_HOLD       4500000

`endif
